// File: hdl/isa_pkg.sv
package isa_pkg;

    // major opcode in bits 31..26, anything not listed decodes as a no-op
    typedef enum logic [5:0] {
        op_add   = 6'h01,
        op_sub   = 6'h02,
        op_slt   = 6'h03,
        op_sltu  = 6'h04,
        op_and   = 6'h05,
        op_or    = 6'h06,
        op_xor   = 6'h07,
        op_sll   = 6'h08,
        op_srl   = 6'h09,
        op_sra   = 6'h0a,
        op_addi  = 6'h0b,
        op_andi  = 6'h0c,
        op_ori   = 6'h0d,
        op_lu12i = 6'h0e,
        op_mul   = 6'h0f,
        op_mulh  = 6'h10,
        op_mulhu = 6'h11,
        op_beq   = 6'h12,
        op_bne   = 6'h13,
        op_blt   = 6'h14,
        op_bltu  = 6'h15,
        op_b     = 6'h16,
        op_bl    = 6'h17,
        op_jirl  = 6'h18
    } opcode_e;

    localparam int opcode_lsb  = 26;
    localparam int rd_lsb      = 0;
    localparam int rj_lsb      = 5;
    localparam int rk_lsb      = 10;
    localparam int reg_field_w = 5;
    localparam int imm12_lsb   = 10;   // bits 21..10
    localparam int imm20_lsb   = 5;    // bits 24..5
    localparam int offs16_lsb  = 10;   // bits 25..10, word offset

endpackage

// File: hdl/exec_pkg.sv
package exec_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;

    typedef enum logic [3:0] {
        alu_add, alu_sub, alu_slt, alu_sltu, alu_and, alu_or,
        alu_xor, alu_sll, alu_srl, alu_sra, alu_lui
    } alu_op_e;

    typedef enum logic [1:0] {
        mul_none, mul_lo, mul_hi_s, mul_hi_u
    } mul_op_e;

    typedef enum logic [2:0] {
        br_none, br_eq, br_ne, br_lt, br_ltu, br_always, br_reg_jump
    } br_kind_e;

    typedef enum logic {
        src2_rk, src2_imm
    } src2_sel_e;

    // link writes pc + 4
    typedef enum logic [1:0] {
        res_alu, res_mul, res_link
    } res_sel_e;

endpackage

// File: hdl/alu.sv
module alu
    import exec_pkg::*;
(
    input  alu_op_e alu_op,
    input  word_t   src1,
    input  word_t   src2,
    output word_t   alu_result,
    output logic    zero,
    output logic    less,
    output logic    less_u
);

    logic [32:0] diff;   // bit 32 is the borrow
    logic [4:0]  shamt;

    assign diff   = {1'b0, src1} - {1'b0, src2};
    assign shamt  = src2[4:0];
    assign zero   = (diff[31:0] == '0);
    assign less_u = diff[32];
    assign less   = (src1[31] != src2[31]) ? src1[31] : diff[31];

    always_comb begin
        case (alu_op)
            alu_add:  alu_result = src1 + src2;
            alu_sub:  alu_result = diff[31:0];
            alu_slt:  alu_result = {31'b0, less};
            alu_sltu: alu_result = {31'b0, less_u};
            alu_and:  alu_result = src1 & src2;
            alu_or:   alu_result = src1 | src2;
            alu_xor:  alu_result = src1 ^ src2;
            alu_sll:  alu_result = src1 << shamt;
            alu_srl:  alu_result = src1 >> shamt;
            alu_sra:  alu_result = word_t'($signed(src1) >>> shamt);
            alu_lui:  alu_result = src2;   // imm already shifted
            default:  alu_result = '0;
        endcase
    end

endmodule

// File: hdl/mul_unit.sv
module mul_unit
    import exec_pkg::*;
(
    input  mul_op_e mul_op,
    input  word_t   src1,
    input  word_t   src2,
    output word_t   mul_result
);

    logic        sign_ext;
    logic [65:0] prod;

    // 33-bit operands cover both signed and unsigned forms
    assign sign_ext = (mul_op == mul_hi_s);
    assign prod     = 66'($signed({sign_ext & src1[31], src1})
                          * $signed({sign_ext & src2[31], src2}));

    assign mul_result = (mul_op == mul_hi_s || mul_op == mul_hi_u) ? prod[63:32]
                                                                    : prod[31:0];

endmodule

// File: hdl/branch_resolve.sv
module branch_resolve
    import exec_pkg::*;
(
    input  br_kind_e br_kind,
    input  logic     zero,
    input  logic     less,
    input  logic     less_u,
    input  word_t    pc,
    input  word_t    rj_value,
    input  word_t    imm,
    output logic     taken,
    output word_t    target
);

    word_t base;
    word_t sum;

    always_comb begin
        case (br_kind)
            br_eq:       taken = zero;
            br_ne:       taken = !zero;
            br_lt:       taken = less;
            br_ltu:      taken = less_u;
            br_always:   taken = 1'b1;
            br_reg_jump: taken = 1'b1;
            default:     taken = 1'b0;
        endcase
    end

    assign base   = (br_kind == br_reg_jump) ? rj_value : pc;
    assign sum    = base + imm;
    assign target = {sum[31:2], 2'b00};   // word aligned

endmodule

// File: hdl/instr_decode.sv
module instr_decode
    import isa_pkg::*;
    import exec_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  logic      in_valid,
    output logic      in_ready,
    input  word_t     in_instr,
    input  word_t     in_pc,
    output reg_addr_t rf_raddr1,
    output reg_addr_t rf_raddr2,
    input  word_t     rf_rdata1,
    input  word_t     rf_rdata2,
    input  logic      es_allowin,
    input  logic      flush,
    input  logic      wb_valid,
    input  logic      wb_we,
    input  reg_addr_t wb_dest,
    input  word_t     wb_data,
    output logic      ds_valid,
    output alu_op_e   alu_op,
    output mul_op_e   mul_op,
    output br_kind_e  br_kind,
    output src2_sel_e src2_sel,
    output res_sel_e  res_sel,
    output logic      src1_is_pc,
    output logic      gr_we,
    output reg_addr_t dest,
    output word_t     imm,
    output word_t     pc,
    output reg_addr_t raddr1,
    output reg_addr_t raddr2,
    output word_t     rj_value,
    output word_t     rkd_value
);

    logic      ds_full;
    logic      ds_allowin;
    word_t     instr_r;
    word_t     pc_r;
    opcode_e   op;
    reg_addr_t rd;
    logic      writes;
    logic      rk_is_rd;   // branches compare rj with rd
    logic      link_r1;
    word_t     simm12;
    word_t     zimm12;
    word_t     uimm20;
    word_t     offs;

    assign ds_allowin = !ds_full || es_allowin;
    assign in_ready   = ds_allowin && !flush;
    assign ds_valid   = ds_full && !flush;   // squash wrong-path word

    always_ff @(posedge clk) begin
        if (reset) begin
            ds_full <= 1'b0;
        end else if (flush) begin
            ds_full <= 1'b0;
        end else if (ds_allowin) begin
            ds_full <= in_valid;
        end
        if (in_valid && in_ready) begin
            instr_r <= in_instr;
            pc_r    <= in_pc;
        end
    end

    assign op     = opcode_e'(instr_r[opcode_lsb +: 6]);
    assign rd     = instr_r[rd_lsb +: reg_field_w];
    assign simm12 = {{20{instr_r[imm12_lsb + 11]}}, instr_r[imm12_lsb +: 12]};
    assign zimm12 = {20'b0, instr_r[imm12_lsb +: 12]};
    assign uimm20 = {instr_r[imm20_lsb +: 20], 12'b0};
    assign offs   = {{14{instr_r[offs16_lsb + 15]}}, instr_r[offs16_lsb +: 16], 2'b00};

    always_comb begin
        alu_op     = alu_add;
        mul_op     = mul_none;
        br_kind    = br_none;
        src2_sel   = src2_rk;
        res_sel    = res_alu;
        src1_is_pc = 1'b0;
        imm        = simm12;
        writes     = 1'b0;
        rk_is_rd   = 1'b0;
        link_r1    = 1'b0;
        case (op)
            op_add:   writes = 1'b1;
            op_sub:   begin alu_op = alu_sub;  writes = 1'b1; end
            op_slt:   begin alu_op = alu_slt;  writes = 1'b1; end
            op_sltu:  begin alu_op = alu_sltu; writes = 1'b1; end
            op_and:   begin alu_op = alu_and;  writes = 1'b1; end
            op_or:    begin alu_op = alu_or;   writes = 1'b1; end
            op_xor:   begin alu_op = alu_xor;  writes = 1'b1; end
            op_sll:   begin alu_op = alu_sll;  writes = 1'b1; end
            op_srl:   begin alu_op = alu_srl;  writes = 1'b1; end
            op_sra:   begin alu_op = alu_sra;  writes = 1'b1; end
            op_addi:  begin src2_sel = src2_imm; writes = 1'b1; end
            op_andi: begin
                alu_op   = alu_and;
                src2_sel = src2_imm;
                imm      = zimm12;
                writes   = 1'b1;
            end
            op_ori: begin
                alu_op   = alu_or;
                src2_sel = src2_imm;
                imm      = zimm12;
                writes   = 1'b1;
            end
            op_lu12i: begin
                alu_op   = alu_lui;
                src2_sel = src2_imm;
                imm      = uimm20;
                writes   = 1'b1;
            end
            op_mul:   begin mul_op = mul_lo;   res_sel = res_mul; writes = 1'b1; end
            op_mulh:  begin mul_op = mul_hi_s; res_sel = res_mul; writes = 1'b1; end
            op_mulhu: begin mul_op = mul_hi_u; res_sel = res_mul; writes = 1'b1; end
            op_beq, op_bne, op_blt, op_bltu: begin
                alu_op   = alu_sub;   // flags only
                imm      = offs;
                rk_is_rd = 1'b1;
                case (op)
                    op_beq:  br_kind = br_eq;
                    op_bne:  br_kind = br_ne;
                    op_blt:  br_kind = br_lt;
                    default: br_kind = br_ltu;
                endcase
            end
            op_b, op_bl: begin
                br_kind    = br_always;
                src1_is_pc = 1'b1;
                src2_sel   = src2_imm;
                imm        = offs;
                res_sel    = res_link;
                writes     = (op == op_bl);
                link_r1    = 1'b1;
            end
            op_jirl: begin
                br_kind  = br_reg_jump;
                src2_sel = src2_imm;
                imm      = offs;
                res_sel  = res_link;
                writes   = 1'b1;
            end
            default: ;   // no-op
        endcase
    end

    assign dest      = link_r1 ? 5'd1 : rd;
    assign gr_we     = writes && (dest != '0);
    assign pc        = pc_r;
    assign rf_raddr1 = instr_r[rj_lsb +: reg_field_w];
    assign rf_raddr2 = rk_is_rd ? rd : instr_r[rk_lsb +: reg_field_w];
    assign raddr1    = rf_raddr1;
    assign raddr2    = rf_raddr2;

    // result stage is two older when this entry moves on
    assign rj_value  = (wb_valid && wb_we && wb_dest == rf_raddr1) ? wb_data : rf_rdata1;
    assign rkd_value = (wb_valid && wb_we && wb_dest == rf_raddr2) ? wb_data : rf_rdata2;

endmodule

// File: hdl/exec_stage.sv
module exec_stage
    import exec_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  logic      ds_valid,
    output logic      es_allowin,
    input  alu_op_e   alu_op,
    input  mul_op_e   mul_op,
    input  br_kind_e  br_kind,
    input  src2_sel_e src2_sel,
    input  res_sel_e  res_sel,
    input  logic      src1_is_pc,
    input  logic      gr_we,
    input  reg_addr_t dest,
    input  word_t     imm,
    input  word_t     pc,
    input  reg_addr_t raddr1,
    input  reg_addr_t raddr2,
    input  word_t     rj_value,
    input  word_t     rkd_value,
    input  logic      rs_allowin,
    input  logic      wb_valid,
    input  logic      wb_we,
    input  reg_addr_t wb_dest,
    input  word_t     wb_data,
    output logic      es_valid,
    output logic      gr_we_o,
    output reg_addr_t dest_o,
    output res_sel_e  res_sel_o,
    output word_t     alu_result,
    output word_t     mul_result,
    output word_t     pc_o,
    output logic      br_taken,
    output word_t     br_target
);

    alu_op_e   alu_op_r;
    mul_op_e   mul_op_r;
    br_kind_e  br_kind_r;
    src2_sel_e src2_sel_r;
    res_sel_e  res_sel_r;
    logic      src1_is_pc_r;
    logic      gr_we_r;
    reg_addr_t dest_r;
    word_t     imm_r;
    word_t     pc_r;
    reg_addr_t raddr1_r;
    reg_addr_t raddr2_r;
    word_t     rj_r;
    word_t     rk_r;
    word_t     rj_fwd;
    word_t     rk_fwd;
    word_t     src1;
    word_t     src2;
    logic      zero;
    logic      less;
    logic      less_u;
    logic      taken;

    assign es_allowin = !es_valid || rs_allowin;

    always_ff @(posedge clk) begin
        if (reset) begin
            es_valid <= 1'b0;
        end else if (es_allowin) begin
            es_valid <= ds_valid;
        end
        if (ds_valid && es_allowin) begin
            alu_op_r     <= alu_op;
            mul_op_r     <= mul_op;
            br_kind_r    <= br_kind;
            src2_sel_r   <= src2_sel;
            res_sel_r    <= res_sel;
            src1_is_pc_r <= src1_is_pc;
            gr_we_r      <= gr_we;
            dest_r       <= dest;
            imm_r        <= imm;
            pc_r         <= pc;
            raddr1_r     <= raddr1;
            raddr2_r     <= raddr2;
            rj_r         <= rj_value;
            rk_r         <= rkd_value;
        end
    end

    // result stage holds the previous instruction
    assign rj_fwd = (wb_valid && wb_we && wb_dest == raddr1_r) ? wb_data : rj_r;
    assign rk_fwd = (wb_valid && wb_we && wb_dest == raddr2_r) ? wb_data : rk_r;
    assign src1   = src1_is_pc_r ? pc_r : rj_fwd;
    assign src2   = (src2_sel_r == src2_imm) ? imm_r : rk_fwd;

    alu u_alu (
        .alu_op    (alu_op_r),
        .src1      (src1),
        .src2      (src2),
        .alu_result(alu_result),
        .zero      (zero),
        .less      (less),
        .less_u    (less_u)
    );

    mul_unit u_mul (
        .mul_op    (mul_op_r),
        .src1      (src1),
        .src2      (src2),
        .mul_result(mul_result)
    );

    branch_resolve u_branch (
        .br_kind (br_kind_r),
        .zero    (zero),
        .less    (less),
        .less_u  (less_u),
        .pc      (pc_r),
        .rj_value(rj_fwd),
        .imm     (imm_r),
        .taken   (taken),
        .target  (br_target)
    );

    assign br_taken  = es_valid && rs_allowin && taken;   // once, as it leaves
    assign gr_we_o   = gr_we_r;
    assign dest_o    = dest_r;
    assign res_sel_o = res_sel_r;
    assign pc_o      = pc_r;

endmodule

// File: hdl/result_stage.sv
module result_stage
    import exec_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  logic      es_valid,
    output logic      rs_allowin,
    input  logic      gr_we,
    input  reg_addr_t dest,
    input  res_sel_e  res_sel,
    input  word_t     alu_result,
    input  word_t     mul_result,
    input  word_t     pc,
    input  logic      wb_allowin,
    output logic      wb_valid,
    output logic      wb_we,
    output reg_addr_t wb_dest,
    output word_t     wb_data,
    output word_t     wb_pc
);

    logic      we_r;
    reg_addr_t dest_r;
    word_t     data_r;
    word_t     pc_r;
    word_t     final_result;

    always_comb begin
        case (res_sel)
            res_mul:  final_result = mul_result;
            res_link: final_result = pc + 32'd4;
            default:  final_result = alu_result;
        endcase
    end

    assign rs_allowin = !wb_valid || wb_allowin;

    always_ff @(posedge clk) begin
        if (reset) begin
            wb_valid <= 1'b0;
        end else if (rs_allowin) begin
            wb_valid <= es_valid;
        end
        if (es_valid && rs_allowin) begin
            we_r   <= gr_we;
            dest_r <= dest;
            data_r <= final_result;
            pc_r   <= pc;
        end
    end

    assign wb_we   = wb_valid && we_r;
    assign wb_dest = dest_r;
    assign wb_data = data_r;
    assign wb_pc   = pc_r;

endmodule

// File: hdl/exm_core.sv
module exm_core
    import exec_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  logic      in_valid,
    output logic      in_ready,
    input  word_t     in_instr,
    input  word_t     in_pc,
    output reg_addr_t rf_raddr1,
    output reg_addr_t rf_raddr2,
    input  word_t     rf_rdata1,
    input  word_t     rf_rdata2,
    output logic      br_taken,
    output word_t     br_target,
    input  logic      wb_allowin,
    output logic      wb_valid,
    output logic      wb_we,
    output reg_addr_t wb_dest,
    output word_t     wb_data,
    output word_t     wb_pc
);

    logic      ds_valid;
    logic      es_allowin;
    alu_op_e   ds_alu_op;
    mul_op_e   ds_mul_op;
    br_kind_e  ds_br_kind;
    src2_sel_e ds_src2_sel;
    res_sel_e  ds_res_sel;
    logic      ds_src1_is_pc;
    logic      ds_gr_we;
    reg_addr_t ds_dest;
    word_t     ds_imm;
    word_t     ds_pc;
    reg_addr_t ds_raddr1;
    reg_addr_t ds_raddr2;
    word_t     ds_rj_value;
    word_t     ds_rkd_value;
    logic      es_valid;
    logic      rs_allowin;
    logic      es_gr_we;
    reg_addr_t es_dest;
    res_sel_e  es_res_sel;
    word_t     es_alu_result;
    word_t     es_mul_result;
    word_t     es_pc;

    instr_decode u_decode (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_instr  (in_instr),
        .in_pc     (in_pc),
        .rf_raddr1 (rf_raddr1),
        .rf_raddr2 (rf_raddr2),
        .rf_rdata1 (rf_rdata1),
        .rf_rdata2 (rf_rdata2),
        .es_allowin(es_allowin),
        .flush     (br_taken),
        .wb_valid  (wb_valid),
        .wb_we     (wb_we),
        .wb_dest   (wb_dest),
        .wb_data   (wb_data),
        .ds_valid  (ds_valid),
        .alu_op    (ds_alu_op),
        .mul_op    (ds_mul_op),
        .br_kind   (ds_br_kind),
        .src2_sel  (ds_src2_sel),
        .res_sel   (ds_res_sel),
        .src1_is_pc(ds_src1_is_pc),
        .gr_we     (ds_gr_we),
        .dest      (ds_dest),
        .imm       (ds_imm),
        .pc        (ds_pc),
        .raddr1    (ds_raddr1),
        .raddr2    (ds_raddr2),
        .rj_value  (ds_rj_value),
        .rkd_value (ds_rkd_value)
    );

    exec_stage u_exec (
        .clk       (clk),
        .reset     (reset),
        .ds_valid  (ds_valid),
        .es_allowin(es_allowin),
        .alu_op    (ds_alu_op),
        .mul_op    (ds_mul_op),
        .br_kind   (ds_br_kind),
        .src2_sel  (ds_src2_sel),
        .res_sel   (ds_res_sel),
        .src1_is_pc(ds_src1_is_pc),
        .gr_we     (ds_gr_we),
        .dest      (ds_dest),
        .imm       (ds_imm),
        .pc        (ds_pc),
        .raddr1    (ds_raddr1),
        .raddr2    (ds_raddr2),
        .rj_value  (ds_rj_value),
        .rkd_value (ds_rkd_value),
        .rs_allowin(rs_allowin),
        .wb_valid  (wb_valid),
        .wb_we     (wb_we),
        .wb_dest   (wb_dest),
        .wb_data   (wb_data),
        .es_valid  (es_valid),
        .gr_we_o   (es_gr_we),
        .dest_o    (es_dest),
        .res_sel_o (es_res_sel),
        .alu_result(es_alu_result),
        .mul_result(es_mul_result),
        .pc_o      (es_pc),
        .br_taken  (br_taken),
        .br_target (br_target)
    );

    result_stage u_result (
        .clk       (clk),
        .reset     (reset),
        .es_valid  (es_valid),
        .rs_allowin(rs_allowin),
        .gr_we     (es_gr_we),
        .dest      (es_dest),
        .res_sel   (es_res_sel),
        .alu_result(es_alu_result),
        .mul_result(es_mul_result),
        .pc        (es_pc),
        .wb_allowin(wb_allowin),
        .wb_valid  (wb_valid),
        .wb_we     (wb_we),
        .wb_dest   (wb_dest),
        .wb_data   (wb_data),
        .wb_pc     (wb_pc)
    );

endmodule

// File: verif/exm_core_assert.sv
module exm_core_assert
    import exec_pkg::*;
(
    input logic      clk,
    input logic      reset,
    input logic      wb_valid,
    input logic      wb_allowin,
    input logic      wb_we,
    input reg_addr_t wb_dest,
    input word_t     wb_data,
    input word_t     wb_pc,
    input logic      br_taken,
    input word_t     br_target
);

    int failures = 0;

    quiet_in_reset: assert property (@(posedge clk) reset |=> (!wb_valid && !br_taken))
        else begin
            $error("wb_valid or br_taken high during reset");
            failures++;
        end

    // stalled entry must hold still
    stall_hold: assert property (@(posedge clk) disable iff (reset)
        wb_valid && !wb_allowin |=> wb_valid && $stable(wb_data) && $stable(wb_pc)
                                    && $stable(wb_we) && $stable(wb_dest))
        else begin
            $error("stalled writeback entry changed");
            failures++;
        end

    no_r0_write: assert property (@(posedge clk) disable iff (reset) !(wb_we && wb_dest == '0))
        else begin
            $error("write enable with destination 0");
            failures++;
        end

    target_aligned: assert property (@(posedge clk) disable iff (reset)
        br_taken |-> br_target[1:0] == 2'b00)
        else begin
            $error("branch target not word aligned");
            failures++;
        end

endmodule

// File: verif/exm_core_tb.sv
module exm_core_tb
    import isa_pkg::*;
    import exec_pkg::*;
();

    localparam int prog_len = 38;

    logic      clk;
    logic      reset;
    logic      in_valid;
    logic      in_ready;
    word_t     in_instr;
    word_t     in_pc;
    reg_addr_t rf_raddr1;
    reg_addr_t rf_raddr2;
    word_t     rf_rdata1;
    word_t     rf_rdata2;
    logic      br_taken;
    word_t     br_target;
    logic      wb_allowin;
    logic      wb_valid;
    logic      wb_we;
    reg_addr_t wb_dest;
    word_t     wb_data;
    word_t     wb_pc;

    word_t     imem [prog_len];
    word_t     prog [prog_len];
    word_t     rf [32];
    word_t     mregs [32];
    word_t     fetch_pc;
    logic      bp_mode;
    word_t     exp_pc [$];
    logic      exp_we [$];
    reg_addr_t exp_dest [$];
    word_t     exp_data [$];

    exm_core exm_core_i (.*);

    bind exm_core exm_core_assert u_assert (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    assign rf_rdata1 = (rf_raddr1 == '0) ? '0 : rf[rf_raddr1];   // r0 reads zero
    assign rf_rdata2 = (rf_raddr2 == '0) ? '0 : rf[rf_raddr2];

    function automatic word_t alu_rr(opcode_e op, reg_addr_t rd, reg_addr_t rj, reg_addr_t rk);
        return {op, 11'b0, rk, rj, rd};
    endfunction

    function automatic word_t alu_ri(opcode_e op, reg_addr_t rd, reg_addr_t rj,
                                     logic [11:0] imm12);
        return {op, 4'b0, imm12, rj, rd};
    endfunction

    function automatic word_t upper_imm(reg_addr_t rd, logic [19:0] imm20);
        return {op_lu12i, 1'b0, imm20, rd};
    endfunction

    function automatic word_t branch_op(opcode_e op, reg_addr_t rj, reg_addr_t rd,
                                        logic [15:0] offs16);
        return {op, offs16, rj, rd};
    endfunction

    task automatic check_word(input string what, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("** Error at %0t: %s got %h expected %h", $time, what, got, exp);
            $display("Regression failed");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic check_dest(input reg_addr_t got, input reg_addr_t exp);
        if (got !== exp) begin
            $display("** Error at %0t: wb_dest got %0d expected %0d", $time, got, exp);
            $display("Regression failed");
            $fatal(1, "destination mismatch");
        end
    endtask

    task automatic check_flag(input string what, input logic got, input logic exp);
        if (got !== exp) begin
            $display("** Error at %0t: %s got %b expected %b", $time, what, got, exp);
            $display("Regression failed");
            $fatal(1, "flag mismatch");
        end
    endtask

    // instruction-set model, program order
    task automatic build_expected();
        word_t       pc;
        word_t       w;
        word_t       a;
        word_t       b;
        word_t       res;
        word_t       nxt;
        word_t       offs;
        opcode_e     op;
        reg_addr_t   rd;
        logic        we;
        logic [63:0] p;
        int          steps;
        pc = 0;
        steps = 0;
        while (pc < prog_len * 4 && steps < 500) begin
            w    = imem[pc >> 2];
            op   = opcode_e'(w[31:26]);
            rd   = w[4:0];
            a    = mregs[w[9:5]];
            b    = mregs[w[14:10]];
            offs = {{14{w[25]}}, w[25:10], 2'b00};
            we   = 1'b1;
            res  = '0;
            nxt  = pc + 4;
            case (op)
                op_add:   res = a + b;
                op_sub:   res = a - b;
                op_slt:   res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                op_sltu:  res = (a < b) ? 32'd1 : 32'd0;
                op_and:   res = a & b;
                op_or:    res = a | b;
                op_xor:   res = a ^ b;
                op_sll:   res = a << b[4:0];
                op_srl:   res = a >> b[4:0];
                op_sra:   res = word_t'($signed(a) >>> b[4:0]);
                op_addi:  res = a + {{20{w[21]}}, w[21:10]};
                op_andi:  res = a & {20'b0, w[21:10]};
                op_ori:   res = a | {20'b0, w[21:10]};
                op_lu12i: res = {w[24:5], 12'b0};
                op_mul:   res = a * b;
                op_mulh: begin
                    p   = $signed({{32{a[31]}}, a}) * $signed({{32{b[31]}}, b});
                    res = p[63:32];
                end
                op_mulhu: begin
                    p   = {32'b0, a} * {32'b0, b};
                    res = p[63:32];
                end
                op_beq, op_bne, op_blt, op_bltu: begin
                    we = 1'b0;
                    b  = mregs[rd];   // compare rj with rd
                    if ((op == op_beq && a == b) || (op == op_bne && a != b)
                        || (op == op_blt && $signed(a) < $signed(b))
                        || (op == op_bltu && a < b))
                        nxt = pc + offs;
                end
                op_b: begin
                    we  = 1'b0;
                    nxt = pc + offs;
                end
                op_bl: begin
                    rd  = 5'd1;
                    res = pc + 4;
                    nxt = pc + offs;
                end
                op_jirl: begin
                    res = pc + 4;
                    nxt = (a + offs) & ~32'd3;
                end
                default: we = 1'b0;
            endcase
            if (rd == '0)
                we = 1'b0;
            exp_pc.push_back(pc);
            exp_we.push_back(we);
            exp_dest.push_back(rd);
            exp_data.push_back(res);
            if (we)
                mregs[rd] = res;
            pc = nxt;
            steps++;
        end
    endtask

    always @(posedge clk) begin : fetch_model
        word_t next_pc;
        if (reset)
            next_pc = '0;
        else if (br_taken)
            next_pc = br_target;
        else if (in_valid && in_ready)
            next_pc = fetch_pc + 4;
        else
            next_pc = fetch_pc;
        fetch_pc   <= next_pc;
        in_valid   <= !reset && (next_pc < prog_len * 4);
        in_instr   <= (next_pc < prog_len * 4) ? imem[next_pc >> 2] : '0;
        in_pc      <= next_pc;
        wb_allowin <= bp_mode ? ($urandom_range(3) != 0) : 1'b1;
    end

    always @(posedge clk) begin : writeback_model
        if (!reset && wb_valid && wb_allowin) begin
            if (exp_pc.size() == 0) begin
                $display("Writeback at pc %h arrived with nothing left to expect", wb_pc);
                $display("Regression failed");
                $fatal(1, "unexpected writeback");
            end else begin
                check_word("wb_pc", wb_pc, exp_pc[0]);
                check_flag("wb_we", wb_we, exp_we[0]);
                if (exp_we[0]) begin
                    check_dest(wb_dest, exp_dest[0]);
                    check_word("wb_data", wb_data, exp_data[0]);
                    rf[wb_dest] <= wb_data;
                end
                void'(exp_pc.pop_front());
                void'(exp_we.pop_front());
                void'(exp_dest.pop_front());
                void'(exp_data.pop_front());
            end
        end
    end

    always @(posedge clk) begin : assert_watch
        if (exm_core_i.u_assert.failures != 0) begin
            $display("A bound protocol assertion failed, see the error above");
            $display("Regression failed");
            $fatal(1, "assertion failure");
        end
    end

    task automatic run_program(input logic random_bp);
        int cycles;
        @(posedge clk);
        reset   <= 1'b1;
        bp_mode <= random_bp;
        rf[0]    = '0;
        mregs[0] = '0;
        for (int r = 1; r < 32; r++) begin
            rf[r]    = $urandom;
            mregs[r] = rf[r];
        end
        build_expected();
        for (int i = 0; i < 3; i++) begin
            @(posedge clk);
            if (i > 0) begin
                check_flag("wb_valid in reset", wb_valid, 1'b0);
                check_flag("br_taken in reset", br_taken, 1'b0);
                check_flag("in_ready in reset", in_ready, 1'b1);
            end
        end
        reset <= 1'b0;
        @(posedge clk);
        check_flag("wb_valid after reset", wb_valid, 1'b0);
        check_flag("br_taken after reset", br_taken, 1'b0);
        check_flag("in_ready after reset", in_ready, 1'b1);
        cycles = 0;
        while (exp_pc.size() > 0 && cycles < 2000) begin
            @(posedge clk);
            cycles++;
        end
        if (exp_pc.size() > 0) begin
            $display("Timed out with %0d writebacks still missing", exp_pc.size());
            $display("Regression failed");
            $fatal(1, "timeout");
        end
        repeat (10) @(posedge clk);   // catch stray writebacks
    endtask

    initial begin
        void'($urandom(60406));
        reset      = 1'b1;
        bp_mode    = 1'b0;
        in_valid   = 1'b0;
        in_instr   = '0;
        in_pc      = '0;
        wb_allowin = 1'b1;
        fetch_pc   = '0;
        prog[0]  = upper_imm(5'd1, 20'h12345);
        prog[1]  = alu_ri(op_ori, 5'd1, 5'd1, 12'h678);
        prog[2]  = alu_ri(op_addi, 5'd2, 5'd1, 12'hfff);   // distance one
        prog[3]  = alu_rr(op_add, 5'd3, 5'd1, 5'd2);
        prog[4]  = alu_rr(op_sub, 5'd4, 5'd3, 5'd5);
        prog[5]  = alu_rr(op_slt, 5'd6, 5'd4, 5'd7);
        prog[6]  = alu_rr(op_sltu, 5'd7, 5'd4, 5'd8);
        prog[7]  = alu_rr(op_and, 5'd8, 5'd9, 5'd10);
        prog[8]  = alu_rr(op_or, 5'd9, 5'd8, 5'd11);
        prog[9]  = alu_rr(op_xor, 5'd10, 5'd9, 5'd8);
        prog[10] = alu_rr(op_sll, 5'd11, 5'd12, 5'd13);
        prog[11] = alu_rr(op_srl, 5'd12, 5'd14, 5'd13);
        prog[12] = alu_rr(op_sra, 5'd13, 5'd15, 5'd14);
        prog[13] = alu_ri(op_andi, 5'd14, 5'd15, 12'hf0f);
        prog[14] = alu_rr(op_add, 5'd0, 5'd1, 5'd2);
        prog[15] = alu_rr(op_mul, 5'd16, 5'd17, 5'd18);
        prog[16] = alu_rr(op_mulh, 5'd19, 5'd17, 5'd18);
        prog[17] = alu_rr(op_mulhu, 5'd20, 5'd17, 5'd18);
        prog[18] = alu_rr(op_mulh, 5'd21, 5'd16, 5'd19);
        prog[19] = branch_op(op_beq, 5'd1, 5'd1, 16'd2);
        prog[20] = alu_ri(op_addi, 5'd22, 5'd0, 12'd1);
        prog[21] = branch_op(op_bne, 5'd1, 5'd1, 16'd5);
        prog[22] = branch_op(op_blt, 5'd4, 5'd3, 16'd2);
        prog[23] = alu_ri(op_addi, 5'd23, 5'd23, 12'd7);
        prog[24] = branch_op(op_bltu, 5'd2, 5'd1, 16'd2);
        prog[25] = alu_ri(op_addi, 5'd24, 5'd0, 12'd9);
        prog[26] = branch_op(op_bl, 5'd0, 5'd0, 16'd3);
        prog[27] = alu_ri(op_addi, 5'd25, 5'd0, 12'd3);
        prog[28] = alu_ri(op_addi, 5'd25, 5'd0, 12'd4);
        prog[29] = alu_ri(op_addi, 5'd26, 5'd1, 12'd0);
        prog[30] = branch_op(op_b, 5'd0, 5'd0, 16'd2);
        prog[31] = alu_ri(op_addi, 5'd27, 5'd0, 12'd5);
        prog[32] = upper_imm(5'd27, 20'h0);
        prog[33] = branch_op(op_jirl, 5'd27, 5'd28, 16'd35);
        prog[34] = alu_ri(op_addi, 5'd29, 5'd0, 12'd6);
        prog[35] = alu_rr(op_add, 5'd29, 5'd28, 5'd28);
        prog[36] = branch_op(op_beq, 5'd0, 5'd0, 16'd2);
        prog[37] = alu_ri(op_addi, 5'd30, 5'd0, 12'd8);
        foreach (prog[i])
            imem[i] = prog[i];
        run_program(1'b0);
        run_program(1'b1);
        if (exm_core_i.u_assert.failures == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// File: exm_core.f
hdl/isa_pkg.sv
hdl/exec_pkg.sv
hdl/alu.sv
hdl/mul_unit.sv
hdl/branch_resolve.sv
hdl/instr_decode.sv
hdl/exec_stage.sv
hdl/result_stage.sv
hdl/exm_core.sv
verif/exm_core_assert.sv
verif/exm_core_tb.sv
